//--- source/lbm_pkg.sv
package lbm_pkg;

    localparam int DATA_W   = 16;
    localparam int NUM_DIR  = 9;
    localparam int COL_BITS = 3;
    localparam int ROW_BITS = 3;

    typedef logic [DATA_W-1:0] dist_t;
    typedef logic [3:0]        dir_t;

    // one cell address, seen as a flat index or as row over column
    typedef union packed {
        logic [ROW_BITS+COL_BITS-1:0] flat;
        struct packed {
            logic [ROW_BITS-1:0] row;
            logic [COL_BITS-1:0] col;
        } rc;
    } cell_addr_u;

    typedef logic [NUM_DIR-1:0][DATA_W-1:0] dist_vec_t;

    // direction ring: 0 rest, then N NE E SE S SW W NW
    // row 0 is the top, so N moves toward row minus one
    function automatic int dir_dx(dir_t d);
        case (d)
            4'd2, 4'd3, 4'd4: return 1;
            4'd6, 4'd7, 4'd8: return -1;
            default:          return 0;
        endcase
    endfunction

    function automatic int dir_dy(dir_t d);
        case (d)
            4'd1, 4'd2, 4'd8: return -1;
            4'd4, 4'd5, 4'd6: return 1;
            default:          return 0;
        endcase
    endfunction

    // four steps round the ring of eight, rest maps to itself
    function automatic dir_t opp_dir(dir_t d);
        if (d == 4'd0)
            return 4'd0;
        return dir_t'(((d + 4'd3) % 4'd8) + 4'd1);
    endfunction

endpackage

//--- source/lattice_sweeper.sv
`timescale 1ns/100ps

module lattice_sweeper
#(
    parameter int GRID_H = 8
)
(
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          start,
    input  logic                                          init,
    input  logic [GRID_H*(1<<lbm_pkg::COL_BITS)-1:0]      barriers,
    input  logic                                          done,
    output logic                                          busy,
    output logic                                          issue_valid,
    output lbm_pkg::cell_addr_u                           issue_cell,
    output lbm_pkg::cell_addr_u                           rd_cell,
    output lbm_pkg::cell_addr_u [lbm_pkg::NUM_DIR-1:0]    src_cell,
    output logic [lbm_pkg::NUM_DIR-1:0]                   bounce,
    output logic                                          self_barrier,
    output logic                                          init_pass
);
    import lbm_pkg::*;

    localparam int GRID_W = 1 << COL_BITS;
    localparam int CELLS  = GRID_H * GRID_W;
    localparam logic [ROW_BITS+COL_BITS-1:0] LAST_CELL = (ROW_BITS+COL_BITS)'(CELLS - 1);

    logic       launch;
    logic       issuing;
    cell_addr_u cell_cnt;

    ////////////////////////////////////////////////////////////
    // pass control
    ////////////////////////////////////////////////////////////

    // a request is taken only while idle, and init wins a tie
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            launch    <= 1'b0;
            busy      <= 1'b0;
            issuing   <= 1'b0;
            init_pass <= 1'b0;
            cell_cnt  <= '0;
        end
        else
        begin
            launch <= (start || init) && !busy && !launch;
            if ((start || init) && !busy && !launch)
                init_pass <= init;

            if (launch)
            begin
                busy          <= 1'b1;
                issuing       <= 1'b1;
                cell_cnt.flat <= '0;
            end
            else if (issuing)
            begin
                cell_cnt.flat <= cell_cnt.flat + 1'b1;
                // last cell leaves this cycle
                if (cell_cnt.flat == LAST_CELL)
                    issuing <= 1'b0;
            end

            if (done)
                busy <= 1'b0;
        end
    end

    assign issue_valid  = issuing;
    assign issue_cell   = cell_cnt;
    assign rd_cell      = cell_cnt;
    assign self_barrier = barriers[cell_cnt.flat];

    ////////////////////////////////////////////////////////////
    // upstream neighbours
    ////////////////////////////////////////////////////////////

    // pull streaming reads direction d from cell minus c_d
    always_comb
    begin
        int   up_row;
        int   up_col;
        logic in_grid;

        for (int d = 0; d < NUM_DIR; d++)
        begin
            up_row  = int'(cell_cnt.rc.row) - dir_dy(dir_t'(d));
            up_col  = int'(cell_cnt.rc.col) - dir_dx(dir_t'(d));
            in_grid = (up_row >= 0) && (up_row < GRID_H) &&
                      (up_col >= 0) && (up_col < GRID_W);

            // off the grid, clamp to the cell itself
            if (in_grid)
            begin
                src_cell[d].rc.row = ROW_BITS'(up_row);
                src_cell[d].rc.col = COL_BITS'(up_col);
            end
            else
            begin
                src_cell[d] = cell_cnt;
            end

            // walls and barrier neighbours both reflect
            bounce[d] = !in_grid || barriers[src_cell[d].flat];
        end

        // rest never moves
        bounce[0] = 1'b0;
    end

endmodule

//--- source/distribution_store.sv
`timescale 1ns/100ps

module distribution_store
#(
    parameter int GRID_H = 8
)
(
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  lbm_pkg::cell_addr_u                           rd_cell,
    input  lbm_pkg::cell_addr_u [lbm_pkg::NUM_DIR-1:0]    src_cell,
    input  logic                                          wr_en,
    input  lbm_pkg::cell_addr_u                           wr_cell,
    input  lbm_pkg::dist_vec_t                            wr_data,
    input  logic                                          done,
    input  lbm_pkg::cell_addr_u                           peek_cell,
    input  lbm_pkg::dir_t                                 peek_dir,
    output lbm_pkg::dist_vec_t                            stream_data,
    output lbm_pkg::dist_vec_t                            own_data,
    output lbm_pkg::dist_t                                peek_data
);
    import lbm_pkg::*;

    localparam int CELLS = GRID_H * (1 << COL_BITS);

    // two banks, one memory per direction
    dist_t mem [2][NUM_DIR][CELLS];
    logic  bank_sel;

    // current bank flips at the end of every pass
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            bank_sel <= 1'b0;
        else if (done)
            bank_sel <= !bank_sel;
    end

    ////////////////////////////////////////////////////////////
    // write port, always into the other bank
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int b = 0; b < 2; b++)
            begin
                for (int d = 0; d < NUM_DIR; d++)
                begin
                    for (int c = 0; c < CELLS; c++)
                        mem[b][d][c] <= '0;
                end
            end
        end
        else if (wr_en)
        begin
            for (int d = 0; d < NUM_DIR; d++)
                mem[!bank_sel][d][wr_cell.flat] <= wr_data[d];
        end
    end

    ////////////////////////////////////////////////////////////
    // registered reads from the current bank
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        for (int d = 0; d < NUM_DIR; d++)
        begin
            // direction d comes from its own upstream cell
            stream_data[d] <= mem[bank_sel][d][src_cell[d].flat];
            own_data[d]    <= mem[bank_sel][d][rd_cell.flat];
        end
        peek_data <= mem[bank_sel][peek_dir][peek_cell.flat];
    end

endmodule

//--- source/stream_writer.sv
`timescale 1ns/100ps

module stream_writer
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            issue_valid,
    input  lbm_pkg::cell_addr_u             issue_cell,
    input  logic [lbm_pkg::NUM_DIR-1:0]     bounce,
    input  logic                            self_barrier,
    input  logic                            init_pass,
    input  lbm_pkg::dist_vec_t              init_f,
    input  lbm_pkg::dist_vec_t              stream_data,
    input  lbm_pkg::dist_vec_t              own_data,
    output logic                            wr_en,
    output lbm_pkg::cell_addr_u             wr_cell,
    output lbm_pkg::dist_vec_t              wr_data,
    output logic                            done
);
    import lbm_pkg::*;

    logic               valid_q;
    cell_addr_u         cell_q;
    logic [NUM_DIR-1:0] bounce_q;
    logic               barrier_q;
    logic               init_q;
    dist_vec_t          next_data;

    ////////////////////////////////////////////////////////////
    // sideband stage, lines up with the store read latency
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        cell_q    <= issue_cell;
        bounce_q  <= bounce;
        barrier_q <= self_barrier;
        init_q    <= init_pass;
    end

    // value select per direction
    always_comb
    begin
        for (int d = 0; d < NUM_DIR; d++)
        begin
            if (barrier_q)
                next_data[d] = '0;
            else if (init_q)
                next_data[d] = init_f[d];
            else if (d == 0)
                next_data[d] = own_data[0];
            else if (bounce_q[d])
                next_data[d] = own_data[opp_dir(dir_t'(d))];
            else
                next_data[d] = stream_data[d];
        end
    end

    ////////////////////////////////////////////////////////////
    // write stage
    ////////////////////////////////////////////////////////////

    // issue has no gaps, so the stream ends where valid_q drops
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_en <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            wr_en <= valid_q;
            done  <= wr_en && !valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        wr_cell <= cell_q;
        wr_data <= next_data;
    end

endmodule

//--- source/lbm_stream_core.sv
`timescale 1ns/100ps

module lbm_stream_core
#(
    parameter int GRID_H = 8
)
(
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        start,
    input  logic                                        init,
    input  logic [GRID_H*(1<<lbm_pkg::COL_BITS)-1:0]    barriers,
    input  lbm_pkg::dist_vec_t                          init_f,
    input  lbm_pkg::cell_addr_u                         peek_cell,
    input  lbm_pkg::dir_t                               peek_dir,
    output logic                                        busy,
    output logic                                        done,
    output lbm_pkg::dist_t                              peek_data
);
    import lbm_pkg::*;

    // sweeper outputs
    logic                     issue_valid;
    cell_addr_u               issue_cell;
    cell_addr_u               rd_cell;
    cell_addr_u [NUM_DIR-1:0] src_cell;
    logic [NUM_DIR-1:0]       bounce;
    logic                     self_barrier;
    logic                     init_pass;

    // read data and write port
    dist_vec_t                stream_data;
    dist_vec_t                own_data;
    logic                     wr_en;
    cell_addr_u               wr_cell;
    dist_vec_t                wr_data;

    lattice_sweeper #(.GRID_H(GRID_H)) u_lattice_sweeper (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .init         (init),
        .barriers     (barriers),
        .done         (done),
        .busy         (busy),
        .issue_valid  (issue_valid),
        .issue_cell   (issue_cell),
        .rd_cell      (rd_cell),
        .src_cell     (src_cell),
        .bounce       (bounce),
        .self_barrier (self_barrier),
        .init_pass    (init_pass)
    );

    distribution_store #(.GRID_H(GRID_H)) u_distribution_store (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_cell     (rd_cell),
        .src_cell    (src_cell),
        .wr_en       (wr_en),
        .wr_cell     (wr_cell),
        .wr_data     (wr_data),
        .done        (done),
        .peek_cell   (peek_cell),
        .peek_dir    (peek_dir),
        .stream_data (stream_data),
        .own_data    (own_data),
        .peek_data   (peek_data)
    );

    stream_writer u_stream_writer (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_cell   (issue_cell),
        .bounce       (bounce),
        .self_barrier (self_barrier),
        .init_pass    (init_pass),
        .init_f       (init_f),
        .stream_data  (stream_data),
        .own_data     (own_data),
        .wr_en        (wr_en),
        .wr_cell      (wr_cell),
        .wr_data      (wr_data),
        .done         (done)
    );

endmodule

//--- sim/lbm_stream_core_asserts.sv
`timescale 1ns/100ps

module lbm_stream_core_asserts
(
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic done,
    input logic wr_en
);

    ////////////////////////////////////////////////////////////
    // pass control timing
    ////////////////////////////////////////////////////////////

    // single cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // busy ends on the edge that closes done
    busy_falls_with_done: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done))
        else $error("busy fell without done");

    // writes only happen inside a pass
    wr_en_in_pass: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> busy)
        else $error("wr_en high while idle");

endmodule

bind lbm_stream_core lbm_stream_core_asserts u_lbm_stream_core_asserts (
    .clk    (clk),
    .arst_n (arst_n),
    .busy   (busy),
    .done   (done),
    .wr_en  (wr_en)
);

//--- sim/tb_lbm_stream_core.sv
`timescale 1ns/100ps

module tb_lbm_stream_core;
    import lbm_pkg::*;

    localparam int GRID_H       = 6;
    localparam int GRID_W       = 8;
    localparam int CELLS        = GRID_H * GRID_W;
    localparam int LATENCY      = CELLS + 3;
    localparam int RESET_CYCLES = 8;
    localparam int PASSES       = 8;
    localparam int CHECKS       = 9;
    localparam int QUIET_CYCLES = CELLS + 10;
    // each pass gets slack, each readout takes one cycle per stored value
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PASSES * (CELLS + 10) + QUIET_CYCLES
                                  + CHECKS * (CELLS * NUM_DIR + 10) + 100;

    // direction ring 0 rest, N NE E SE S SW W NW, row 0 at the top
    localparam int DX  [NUM_DIR] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int DY  [NUM_DIR] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};
    localparam int OPP [NUM_DIR] = '{0, 5, 6, 7, 8, 1, 2, 3, 4};

    logic             clk;
    logic             arst_n;
    logic             start;
    logic             init;
    logic [CELLS-1:0] barriers;
    dist_vec_t        init_f;
    cell_addr_u       peek_cell;
    dir_t             peek_dir;
    logic             busy;
    logic             done;
    dist_t            peek_data;

    // expected lattice
    dist_t model [NUM_DIR][CELLS];
    logic  check_req;

    lbm_stream_core #(.GRID_H(GRID_H)) u_lbm_stream_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .init      (init),
        .barriers  (barriers),
        .init_f    (init_f),
        .peek_cell (peek_cell),
        .peek_dir  (peek_dir),
        .busy      (busy),
        .done      (done),
        .peek_data (peek_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_dist(input string name, input dist_t got, input dist_t exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "distribution value wrong");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "control flag wrong");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference lattice model
    ////////////////////////////////////////////////////////////

    function automatic void init_model(input logic [CELLS-1:0] bar, input dist_vec_t f);
        for (int c = 0; c < CELLS; c++)
        begin
            for (int d = 0; d < NUM_DIR; d++)
                model[d][c] = bar[c] ? dist_t'(0) : f[d];
        end
    endfunction

    // pull from the upstream cell, reflect off walls and barriers
    function automatic void step_model(input logic [CELLS-1:0] bar);
        dist_t nxt [NUM_DIR][CELLS];
        int    up_row;
        int    up_col;
        logic  off_grid;
        for (int c = 0; c < CELLS; c++)
        begin
            for (int d = 0; d < NUM_DIR; d++)
            begin
                up_row   = c / GRID_W - DY[d];
                up_col   = c % GRID_W - DX[d];
                off_grid = (up_row < 0) || (up_row >= GRID_H) ||
                           (up_col < 0) || (up_col >= GRID_W);
                if (bar[c])
                    nxt[d][c] = '0;
                else if (d == 0)
                    nxt[d][c] = model[0][c];
                else if (off_grid)
                    nxt[d][c] = model[OPP[d]][c];
                else if (bar[up_row * GRID_W + up_col])
                    nxt[d][c] = model[OPP[d]][c];
                else
                    nxt[d][c] = model[d][up_row * GRID_W + up_col];
            end
        end
        model = nxt;
    endfunction

    // about one cell in five
    function automatic logic [CELLS-1:0] random_barriers();
        logic [CELLS-1:0] bar;
        for (int c = 0; c < CELLS; c++)
            bar[c] = ($urandom % 5) == 0;
        return bar;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // one pass, done must land exactly LATENCY cycles after sampling
    task automatic run_pass(input logic is_init, input logic stray_start);
        @(negedge clk);
        init  = is_init;
        start = !is_init;
        @(negedge clk);
        init  = 1'b0;
        start = 1'b0;
        check_flag("busy", busy, 1'b0);
        for (int lat = 1; lat <= LATENCY; lat++)
        begin
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
            check_flag("done", done, lat == LATENCY);
            // a second start mid pass has to be dropped
            start = stray_start && (lat == CELLS / 2);
        end
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    task automatic compare_lattice();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    initial
    begin : stimulus
        void'($urandom(16351));
        arst_n    = 1'b0;
        start     = 1'b0;
        init      = 1'b0;
        barriers  = '0;
        init_f    = '0;
        check_req = 1'b0;
        for (int c = 0; c < CELLS; c++)
        begin
            for (int d = 0; d < NUM_DIR; d++)
                model[d][c] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // memories come out of reset cleared
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        compare_lattice();

        barriers = random_barriers();
        for (int d = 0; d < NUM_DIR; d++)
            init_f[d] = dist_t'($urandom);
        run_pass(1'b1, 1'b0);
        init_model(barriers, init_f);
        compare_lattice();

        // open grid, only the outer walls reflect
        barriers = '0;
        run_pass(1'b0, 1'b0);
        step_model(barriers);
        compare_lattice();

        repeat (5)
        begin
            barriers = random_barriers();
            run_pass(1'b0, 1'b0);
            step_model(barriers);
            compare_lattice();
        end

        barriers = random_barriers();
        run_pass(1'b0, 1'b1);
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
        end
        step_model(barriers);
        compare_lattice();

        $display("Simulation PASSED");
        $finish;
    end

    // peeks every stored value and compares it with the model
    initial
    begin : compare_proc
        peek_cell = '0;
        peek_dir  = '0;
        forever
        begin
            wait (check_req);
            @(negedge clk);
            for (int c = 0; c < CELLS; c++)
            begin
                for (int d = 0; d < NUM_DIR; d++)
                begin
                    peek_cell.flat = 6'(c);
                    peek_dir       = dir_t'(d);
                    @(negedge clk);
                    check_dist($sformatf("peek_data cell %0d dir %0d", c, d),
                               peek_data, model[d][c]);
                end
            end
            check_req = 1'b0;
        end
    end

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- files.f
source/lbm_pkg.sv
source/lattice_sweeper.sv
source/distribution_store.sv
source/stream_writer.sv
source/lbm_stream_core.sv
sim/lbm_stream_core_asserts.sv
sim/tb_lbm_stream_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lbm_stream_core -f files.f \
    && ./obj_dir/Vtb_lbm_stream_core \
    || exit 1
